// ==== hdl/uart_bridge_pkg.sv ====
package uart_bridge_pkg;

    // Serial bit timing
    localparam int CLKS_PER_BIT = 16;                      // Clocks per UART bit
    localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [BIT_CNT_W-1:0] BIT_END = BIT_CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [BIT_CNT_W-1:0] BIT_MID = BIT_CNT_W'(CLKS_PER_BIT / 2 - 1);

    // Inter-byte timeout, 40 bit periods
    localparam int TIMEOUT_CLKS = 40 * CLKS_PER_BIT;
    localparam int TMO_CNT_W = $clog2(TIMEOUT_CLKS);
    localparam logic [TMO_CNT_W-1:0] TMO_END = TMO_CNT_W'(TIMEOUT_CLKS - 1);

    // Register bus widths and command byte layout
    localparam int DATA_W = 32;
    localparam int IDX_W = 7;                              // Low bits of command byte
    localparam int CMD_WRITE_BIT = 7;                      // 1 = write

    // Register map
    localparam logic [IDX_W-1:0] REG_CTRL = 7'd0;          // Bit 0 bridge enable
    localparam logic [IDX_W-1:0] REG_SCRATCH0 = 7'd1;
    localparam logic [IDX_W-1:0] REG_SCRATCH1 = 7'd2;
    localparam logic [IDX_W-1:0] REG_ID = 7'd3;            // Read only
    localparam logic [IDX_W-1:0] REG_STATUS = 7'd4;        // Read only, counters
    localparam logic [DATA_W-1:0] ID_VALUE = 32'h5541_5254;

    // Reply status codes, zero-extended into the status byte
    localparam int ST_W = 2;
    localparam logic [ST_W-1:0] ST_OK = 2'd0;
    localparam logic [ST_W-1:0] ST_BAD_ADDR = 2'd1;
    localparam logic [ST_W-1:0] ST_READ_ONLY = 2'd2;
    localparam logic [ST_W-1:0] ST_TIMEOUT = 2'd3;

    // Receiver FSM states
    localparam logic [1:0] RX_IDLE = 2'd0;
    localparam logic [1:0] RX_START = 2'd1;
    localparam logic [1:0] RX_DATA = 2'd2;
    localparam logic [1:0] RX_STOP = 2'd3;

    // Command engine FSM states
    localparam logic [1:0] CE_IDLE = 2'd0;
    localparam logic [1:0] CE_DATA = 2'd1;                 // Collecting write bytes
    localparam logic [1:0] CE_ACCESS = 2'd2;               // Register strobe cycle
    localparam logic [1:0] CE_REPLY = 2'd3;

endpackage

// ==== hdl/reg_bus_if.sv ====
`timescale 1ns/1ps

interface reg_bus_if;
    import uart_bridge_pkg::*;

    logic              wr_en;   // One-cycle write strobe
    logic              rd_en;   // One-cycle read strobe
    logic [IDX_W-1:0]  idx;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;   // Combinational from idx
    // Access status, ST_OK when the access is legal
    logic [ST_W-1:0]   err;

    // Command engine side
    modport master (
        output wr_en,
        output rd_en,
        output idx,
        output wdata,
        input  rdata,
        input  err
    );

    // Register block side
    modport slave (
        input  wr_en,
        input  rd_en,
        input  idx,
        input  wdata,
        output rdata,
        output err
    );

endinterface

// ==== hdl/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,
    output logic       rx_valid,
    output logic [7:0] rx_data,
    output logic       rx_frame_err
);
    import uart_bridge_pkg::*;

    logic [1:0]           rx_sync;   // Two-flop synchroniser
    logic                 rx_prev;   // For falling edge detect
    logic                 rx_line;
    logic [1:0]           state;
    logic [BIT_CNT_W-1:0] cnt;
    logic [2:0]           bit_idx;
    logic [7:0]           shreg;

    assign rx_line = rx_sync[1];
    assign rx_data = shreg;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_sync <= 2'b11;   // Line idles high
            rx_prev <= 1'b1;
        end else begin
            rx_sync <= {rx_sync[0], rx};
            rx_prev <= rx_line;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= RX_IDLE;
            cnt          <= '0;
            bit_idx      <= '0;
            rx_valid     <= 1'b0;
            rx_frame_err <= 1'b0;
        end else begin
            rx_valid     <= 1'b0;
            rx_frame_err <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (rx_prev && !rx_line) begin   // Start edge
                        state <= RX_START;
                        cnt   <= '0;
                    end
                end
                RX_START: begin
                    if (cnt == BIT_MID) begin
                        // Glitch check at mid start bit
                        state   <= rx_line ? RX_IDLE : RX_DATA;
                        cnt     <= '0;
                        bit_idx <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cnt == BIT_END) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= RX_STOP;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin   // RX_STOP
                    if (cnt == BIT_END) begin
                        rx_valid     <= rx_line;    // Good stop bit
                        rx_frame_err <= !rx_line;   // Byte dropped
                        state        <= RX_IDLE;
                        cnt          <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && cnt == BIT_END) shreg <= {rx_line, shreg[7:1]};
    end

endmodule

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    input  logic       cts_n,
    output logic       tx,
    output logic       tx_busy
);
    import uart_bridge_pkg::*;

    logic [9:0]           shreg;     // Stop, data, start
    logic                 sending;   // Low while waiting on cts_n
    logic [BIT_CNT_W-1:0] cnt;
    logic [3:0]           bit_idx;
    logic                 bit_done;

    assign tx       = sending ? shreg[0] : 1'b1;   // Idle high
    assign bit_done = sending && (cnt == BIT_END);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_busy <= 1'b0;
            sending <= 1'b0;
            cnt     <= '0;
            bit_idx <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx_busy <= 1'b1;
                sending <= !cts_n;   // Start bit next cycle if host ready
                cnt     <= '0;
                bit_idx <= '0;
            end
        end else if (!sending) begin
            // Byte parked until host clears to send
            if (!cts_n) sending <= 1'b1;
        end else if (bit_done) begin
            cnt <= '0;
            if (bit_idx == 4'd9) begin   // End of stop bit
                tx_busy <= 1'b0;
                sending <= 1'b0;
            end else begin
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!tx_busy && tx_start) begin
            shreg <= {1'b1, tx_data, 1'b0};
        end else if (bit_done) begin
            shreg <= {1'b1, shreg[9:1]};   // Next bit out
        end
    end

endmodule

// ==== hdl/cmd_engine.sv ====
`timescale 1ns/1ps

module cmd_engine (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx_valid,
    input  logic [7:0] rx_data,
    input  logic       bridge_enable,
    input  logic       tx_busy,
    output logic       tx_start,
    output logic [7:0] tx_data,
    output logic       cmd_done,
    output logic       rts_n,
    reg_bus_if.master  bus
);
    import uart_bridge_pkg::*;

    logic [1:0]           state;
    logic [7:0]           cmd_q;       // Command byte
    logic [1:0]           byte_cnt;    // Write data bytes seen
    logic [TMO_CNT_W-1:0] tmo_cnt;
    logic [DATA_W-1:0]    wdata_q;
    logic [DATA_W-1:0]    rdata_q;     // Read data, shifted out LSB first
    logic [2:0]           left;        // Data bytes still to send
    logic                 tmo_reply;   // Current reply is a timeout
    logic                 locked;      // Frame in flight, host held off
    logic                 is_write;
    logic                 last_byte;
    logic                 tmo_hit;
    logic                 next_byte;
    logic [7:0]           status_byte;

    assign is_write    = cmd_q[CMD_WRITE_BIT];
    assign status_byte = {{(8 - ST_W){1'b0}}, bus.err};
    assign tmo_hit     = (state == CE_DATA) && !rx_valid && (tmo_cnt == TMO_END);
    // Previous byte out and acknowledged by uart_tx
    assign next_byte   = (state == CE_REPLY) && !tx_start && !tx_busy && (left != 3'd0);

    // Frame ends on a read command or on the fourth write byte
    always_comb begin
        last_byte = 1'b0;
        if (rx_valid) begin
            if (state == CE_IDLE) last_byte = !rx_data[CMD_WRITE_BIT];
            else if (state == CE_DATA) last_byte = (byte_cnt == 2'd3);
        end
    end

    // Single register access while in CE_ACCESS
    assign bus.wr_en = (state == CE_ACCESS) && is_write;
    assign bus.rd_en = (state == CE_ACCESS) && !is_write;
    assign bus.idx   = cmd_q[IDX_W-1:0];
    assign bus.wdata = wdata_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= CE_IDLE;
            byte_cnt  <= '0;
            tmo_cnt   <= '0;
            left      <= '0;
            tmo_reply <= 1'b0;
            locked    <= 1'b0;
            tx_start  <= 1'b0;
            cmd_done  <= 1'b0;
            rts_n     <= 1'b1;   // Not ready in reset
        end else begin
            tx_start <= 1'b0;
            cmd_done <= 1'b0;
            rts_n    <= !bridge_enable || locked;
            if (last_byte) begin
                state  <= CE_ACCESS;
                locked <= 1'b1;
                rts_n  <= 1'b1;
            end
            case (state)
                CE_IDLE: begin
                    if (rx_valid && rx_data[CMD_WRITE_BIT]) begin
                        state    <= CE_DATA;
                        byte_cnt <= '0;
                        tmo_cnt  <= '0;
                    end
                end
                CE_DATA: begin
                    if (rx_valid) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        tmo_cnt  <= '0;   // Restart per byte
                    end else if (tmo_hit) begin
                        state     <= CE_REPLY;   // Abandon frame
                        tmo_reply <= 1'b1;
                        left      <= '0;
                        tx_start  <= 1'b1;
                    end else begin
                        tmo_cnt <= tmo_cnt + 1'b1;
                    end
                end
                CE_ACCESS: begin
                    state     <= CE_REPLY;
                    tmo_reply <= 1'b0;
                    tx_start  <= 1'b1;   // Status byte first
                    left      <= (!is_write && bus.err == ST_OK) ? 3'd4 : 3'd0;
                end
                default: begin   // CE_REPLY
                    if (next_byte) begin
                        tx_start <= 1'b1;
                        left     <= left - 1'b1;
                    end else if (!tx_start && !tx_busy) begin
                        state    <= CE_IDLE;
                        cmd_done <= !tmo_reply;   // Timeouts are not counted
                        locked   <= 1'b0;
                        rts_n    <= !bridge_enable;
                    end
                end
            endcase
        end
    end

    // Frame and reply payload
    always_ff @(posedge clk) begin
        if (state == CE_IDLE && rx_valid) cmd_q <= rx_data;
        if (state == CE_DATA && rx_valid) wdata_q[byte_cnt*8 +: 8] <= rx_data;   // LSB first
        if (tmo_hit) tx_data <= {{(8 - ST_W){1'b0}}, ST_TIMEOUT};
        if (state == CE_ACCESS) begin
            tx_data <= status_byte;
            rdata_q <= bus.rdata;
        end
        if (next_byte) begin
            tx_data <= rdata_q[7:0];
            rdata_q <= rdata_q >> 8;
        end
    end

endmodule

// ==== hdl/reg_block.sv ====
`timescale 1ns/1ps

module reg_block (
    input  logic      clk,
    input  logic      rst,
    reg_bus_if.slave  bus,
    input  logic      cmd_done,
    input  logic      rx_frame_err,
    output logic      bridge_enable
);
    import uart_bridge_pkg::*;

    logic [DATA_W-1:0] scratch0;
    logic [DATA_W-1:0] scratch1;
    logic [15:0]       cmd_cnt;    // Completed commands, wraps
    logic [7:0]        ferr_cnt;   // Framing errors, wraps
    logic              bad_idx;
    logic              ro_idx;
    logic              wr_ok;

    assign bad_idx = bus.idx > REG_STATUS;
    assign ro_idx  = (bus.idx == REG_ID) || (bus.idx == REG_STATUS);

    // Access check, bad index takes priority
    always_comb begin
        bus.err = ST_OK;
        if ((bus.wr_en || bus.rd_en) && bad_idx) begin
            bus.err = ST_BAD_ADDR;
        end else if (bus.wr_en && ro_idx) begin
            bus.err = ST_READ_ONLY;
        end
    end

    assign wr_ok = bus.wr_en && (bus.err == ST_OK);

    // Read mux
    always_comb begin
        case (bus.idx)
            REG_CTRL:     bus.rdata = {{(DATA_W - 1){1'b0}}, bridge_enable};
            REG_SCRATCH0: bus.rdata = scratch0;
            REG_SCRATCH1: bus.rdata = scratch1;
            REG_ID:       bus.rdata = ID_VALUE;
            REG_STATUS:   bus.rdata = {{(DATA_W - 24){1'b0}}, ferr_cnt, cmd_cnt};
            default:      bus.rdata = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bridge_enable <= 1'b1;   // Enabled out of reset
            scratch0      <= '0;
            scratch1      <= '0;
        end else if (wr_ok) begin
            case (bus.idx)
                REG_CTRL:     bridge_enable <= bus.wdata[0];
                REG_SCRATCH0: scratch0 <= bus.wdata;
                REG_SCRATCH1: scratch1 <= bus.wdata;
                default:      ;   // Nothing writable here
            endcase
        end
    end

    // Statistics
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_cnt  <= '0;
            ferr_cnt <= '0;
        end else begin
            if (cmd_done) cmd_cnt <= cmd_cnt + 1'b1;
            if (rx_frame_err) ferr_cnt <= ferr_cnt + 1'b1;
        end
    end

endmodule

// ==== hdl/uart_bridge_top.sv ====
`timescale 1ns/1ps

module uart_bridge_top (
    input  logic clk,
    input  logic rst,
    input  logic uart_rx,
    output logic uart_tx,
    output logic uart_rts_n,   // Active low, registered in cmd_engine
    input  logic uart_cts_n    // Active low, from host
);

    // Receiver to engine and statistics
    logic       rx_valid;
    logic [7:0] rx_data;
    logic       rx_frame_err;

    // Engine to transmitter
    logic       tx_start;
    logic [7:0] tx_data;
    logic       tx_busy;

    logic       cmd_done;        // Reply finished
    logic       bridge_enable;   // CTRL bit 0

    reg_bus_if reg_bus ();

    uart_rx i_uart_rx (
        .clk          (clk),
        .rst          (rst),
        .rx           (uart_rx),
        .rx_valid     (rx_valid),
        .rx_data      (rx_data),
        .rx_frame_err (rx_frame_err)
    );

    uart_tx i_uart_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .cts_n    (uart_cts_n),
        .tx       (uart_tx),
        .tx_busy  (tx_busy)
    );

    cmd_engine i_cmd_engine (
        .clk           (clk),
        .rst           (rst),
        .rx_valid      (rx_valid),
        .rx_data       (rx_data),
        .bridge_enable (bridge_enable),
        .tx_busy       (tx_busy),
        .tx_start      (tx_start),
        .tx_data       (tx_data),
        .cmd_done      (cmd_done),
        .rts_n         (uart_rts_n),
        .bus           (reg_bus.master)
    );

    reg_block i_reg_block (
        .clk           (clk),
        .rst           (rst),
        .bus           (reg_bus.slave),
        .cmd_done      (cmd_done),
        .rx_frame_err  (rx_frame_err),
        .bridge_enable (bridge_enable)
    );

endmodule

// ==== tests/tb_uart_bridge.sv ====
`timescale 1ns/1ps

module tb_uart_bridge;
    import uart_bridge_pkg::*;

    logic clk;
    logic rst;
    logic uart_rx;      // Host to bridge
    logic uart_tx;      // Bridge to host
    logic uart_rts_n;
    logic uart_cts_n;   // Host back-pressure

    logic [31:0]      rng;            // xorshift state
    logic [15:0]      cmd_model;      // Expected completed commands
    logic [7:0]       ferr_model;     // Expected framing errors
    logic             enable_model;   // Expected CTRL bit 0
    int               fd;
    int               n_fields;
    int               n_ops;
    logic [7:0]       op_code;        // Single character opcode
    logic [31:0]      f_a;
    logic [31:0]      f_b;
    logic [31:0]      f_c;
    logic [31:0]      f_d;
    logic [8*128-1:0] rest_of_line;

    uart_bridge_top i_uart_bridge_top (
        .clk        (clk),
        .rst        (rst),
        .uart_rx    (uart_rx),
        .uart_tx    (uart_tx),
        .uart_rts_n (uart_rts_n),
        .uart_cts_n (uart_cts_n)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // STATUS reads come from the counter model, all others from the file
    function automatic logic [DATA_W-1:0] expected_read(input logic [IDX_W-1:0] idx,
                                                        input logic [DATA_W-1:0] from_file);
        if (idx == REG_STATUS) return DATA_W'({ferr_model, cmd_model});
        return from_file;
    endfunction

    task automatic stop_with_failure();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        stop_with_failure();
    endtask

    task automatic check_fields(input int got, input int want);
        if (got != want) begin
            $display("Pattern line for op %s has %0d fields, needs %0d", op_code, got, want);
            stop_with_failure();
        end
    endtask

    task automatic check_status(input logic [7:0] got, input logic [7:0] want, input string what);
        if (got !== want) begin
            $display("** Error at %0t: %s is %02h, expected %02h", $time, what, got, want);
            stop_with_failure();
        end
    endtask

    task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] want,
                              input string what);
        if (got !== want) begin
            $display("** Error at %0t: %s is %08h, expected %08h", $time, what, got, want);
            stop_with_failure();
        end
    endtask

    task automatic check_level(input logic got, input logic want, input string what);
        if (got !== want) begin
            $display("** Error at %0t: %s is %b, expected %b", $time, what, got, want);
            stop_with_failure();
        end
    endtask

    task automatic idle_gap();
        rng = xorshift32(rng);
        repeat (rng[5:0]) @(negedge clk);   // At most 63 clocks, far below the timeout
    endtask

    // One 8N1 byte, stop_bit low gives a framing error
    task automatic send_byte(input logic [7:0] b, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, b, 1'b0};
        for (int k = 0; k < 10; k++) begin
            @(negedge clk);
            uart_rx = bits[k];
            repeat (CLKS_PER_BIT - 1) @(negedge clk);
        end
        if (!stop_bit) begin
            @(negedge clk);
            uart_rx = 1'b1;   // Back to idle
        end
    endtask

    task automatic send_frame(input logic [7:0] cmd, input logic [DATA_W-1:0] data,
                              input int n_data);
        send_byte(cmd, 1'b1);
        for (int k = 0; k < n_data; k++) begin
            idle_gap();
            send_byte(data[k*8 +: 8], 1'b1);   // LSB first
        end
    endtask

    task automatic get_byte(output logic [7:0] b, input int limit, input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while (uart_tx !== 1'b0) begin
            if (waited >= limit) report_timeout(what);
            waited++;
            @(negedge clk);
        end
        repeat (CLKS_PER_BIT / 2) @(negedge clk);   // Middle of start bit
        check_level(uart_tx, 1'b0, "reply start bit");
        for (int k = 0; k < 8; k++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            b[k] = uart_tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        check_level(uart_tx, 1'b1, "reply stop bit");
    endtask

    task automatic expect_reply(input logic [7:0] st, input logic is_read,
                                input logic [DATA_W-1:0] want);
        logic [7:0]        b;
        logic [DATA_W-1:0] word;
        word = '0;
        // Covers a full write frame plus the inter-byte timeout
        get_byte(b, TIMEOUT_CLKS + 80 * CLKS_PER_BIT, "reply status byte");
        check_status(b, st, "reply status");
        if (is_read && st == 8'(ST_OK)) begin
            for (int k = 0; k < DATA_W / 8; k++) begin
                get_byte(b, 4 * CLKS_PER_BIT, "reply data byte");
                word[k*8 +: 8] = b;
            end
            check_word(word, want, "read data");
        end
    endtask

    // rts_n settles once cmd_done has passed
    task automatic settle_rts();
        logic rts_want;
        int   waited;
        rts_want = !enable_model;
        waited = 0;
        if (rts_want) begin
            // Disabled bridge keeps rts_n high past the end of the reply
            repeat (2 * CLKS_PER_BIT) begin
                @(negedge clk);
                check_level(uart_rts_n, 1'b1, "rts_n while bridge disabled");
            end
        end else begin
            while (uart_rts_n !== 1'b0) begin
                if (waited >= 4 * CLKS_PER_BIT) report_timeout("rts_n to fall after reply");
                waited++;
                @(negedge clk);
            end
        end
    endtask

    task automatic run_write(input logic [IDX_W-1:0] idx, input logic [DATA_W-1:0] data,
                             input logic [7:0] st);
        fork
            send_frame({1'b1, idx}, data, DATA_W / 8);
            expect_reply(st, 1'b0, '0);
        join
        if (st == 8'(ST_OK) && idx == REG_CTRL) enable_model = data[0];
        cmd_model = cmd_model + 16'd1;   // Error replies count too
        settle_rts();
    endtask

    // span above zero holds cts_n high that many clocks after the frame
    task automatic run_read(input logic [IDX_W-1:0] idx, input logic [7:0] st,
                            input logic [DATA_W-1:0] data, input int span);
        logic [DATA_W-1:0] want;
        want = expected_read(idx, data);
        if (span == 0) begin
            fork
                send_frame({1'b0, idx}, '0, 0);
                expect_reply(st, 1'b1, want);
            join
        end else begin
            uart_cts_n = 1'b1;
            send_frame({1'b0, idx}, '0, 0);
            repeat (span) begin
                @(negedge clk);
                check_level(uart_tx, 1'b1, "tx line while cts_n high");
            end
            uart_cts_n = 1'b0;   // Release parked reply
            expect_reply(st, 1'b1, want);
        end
        cmd_model = cmd_model + 16'd1;
        settle_rts();
    endtask

    task automatic run_timeout(input logic [IDX_W-1:0] idx, input int n_data);
        rng = xorshift32(rng);
        fork
            send_frame({1'b1, idx}, rng, n_data);
            expect_reply(8'(ST_TIMEOUT), 1'b0, '0);
        join
        settle_rts();   // Timeouts leave the command count alone
    endtask

    task automatic run_frame_err();
        rng = xorshift32(rng);
        send_byte(rng[7:0], 1'b0);
        ferr_model = ferr_model + 8'd1;
        repeat (3 * CLKS_PER_BIT) begin
            @(negedge clk);
            check_level(uart_tx, 1'b1, "tx line after framing error");
        end
    endtask

    initial begin
        rst = 1'b1;
        uart_rx = 1'b1;
        uart_cts_n = 1'b0;
        rng = 32'hcdf8;
        cmd_model = '0;
        ferr_model = '0;
        enable_model = 1'b1;
        n_ops = 0;
        repeat (3) @(negedge clk);
        check_level(uart_tx, 1'b1, "tx line in reset");
        check_level(uart_rts_n, 1'b1, "rts_n in reset");
        rst = 1'b0;
        @(negedge clk);
        check_level(uart_rts_n, 1'b0, "rts_n after reset release");   // One cycle later
        check_level(uart_tx, 1'b1, "tx line after reset");

        fd = $fopen("tests/uart_bridge_patterns.txt", "r");
        if (fd == 0) begin
            $display("Pattern file tests/uart_bridge_patterns.txt could not be opened");
            stop_with_failure();
        end
        op_code = '0;
        while ($fscanf(fd, "%s", op_code) == 1) begin
            case (op_code)
                "#": n_fields = $fgets(rest_of_line, fd);   // Comment line
                "W": begin
                    n_fields = $fscanf(fd, "%h %h %h", f_a, f_b, f_c);
                    check_fields(n_fields, 3);
                    run_write(f_a[IDX_W-1:0], f_b, f_c[7:0]);
                end
                "R": begin
                    n_fields = $fscanf(fd, "%h %h %h", f_a, f_b, f_c);
                    check_fields(n_fields, 3);
                    run_read(f_a[IDX_W-1:0], f_b[7:0], f_c, 0);
                end
                "C": begin
                    n_fields = $fscanf(fd, "%h %h %h %h", f_a, f_b, f_c, f_d);
                    check_fields(n_fields, 4);
                    run_read(f_a[IDX_W-1:0], f_b[7:0], f_c, int'(f_d));
                end
                "T": begin
                    n_fields = $fscanf(fd, "%h %h", f_a, f_b);
                    check_fields(n_fields, 2);
                    run_timeout(f_a[IDX_W-1:0], int'(f_b));
                end
                "F": run_frame_err();
                default: begin
                    $display("Unknown operation %s in pattern file", op_code);
                    stop_with_failure();
                end
            endcase
            if (op_code != "#") begin
                n_ops++;
                idle_gap();
            end
            op_code = '0;
        end
        $fclose(fd);

        if (n_ops > 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("Pattern file held no operations");
            stop_with_failure();
        end
    end

endmodule

// ==== tests/uart_bridge_patterns.txt ====
# Hex fields. W idx data status, R idx status data, C idx status data cts_hold_clocks
# T idx write_bytes_sent, F sends one byte with a low stop bit. Index 04 data is modelled
R 03 0 55415254
R 00 0 00000001
W 01 deadbeef 0
W 02 0123abcd 0
R 01 0 deadbeef
R 02 0 0123abcd
R 05 1 00000000
W 7f 00000000 1
W 03 12345678 2
W 04 ffffffff 2
R 03 0 55415254
R 04 0 00000000
T 01 2
R 01 0 deadbeef
T 02 0
R 02 0 0123abcd
F
F
R 04 0 00000000
C 01 0 deadbeef 100
W 00 00000000 0
R 00 0 00000000
W 00 00000001 0
R 00 0 00000001
C 04 0 00000000 40

// ==== all.f ====
hdl/uart_bridge_pkg.sv
hdl/reg_bus_if.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/cmd_engine.sv
hdl/reg_block.sv
hdl/uart_bridge_top.sv
tests/tb_uart_bridge.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module tb_uart_bridge -f all.f

sim_out=$(./obj_dir/Vtb_uart_bridge 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
